//--- mem_system.f
+incdir+src
src/mem_system_pkg.sv
src/cache_array.sv
src/cache_ctrl.sv
src/mem_arbiter.sv
src/banked_mem.sv
src/mem_system.sv
tests/tb_clock.sv
tests/tb_mem_system.sv

//--- Makefile
# Verilator build and run of the two-port memory subsystem testbench
VERILATOR := verilator
VFLAGS    := --binary --timing --assert -j 0
TOP       := tb_mem_system
FILELIST  := mem_system.f
OBJ_DIR   := obj_dir
PASS_MSG  := === PASS ===

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build with Verilator, run the testbench, fail unless it passes"
	@echo "  clean  remove the Verilator build directory"
	@echo "  help   show this list"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qF -- "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)

//--- tests/tb_mem_system.sv
// directed testbench for the two-port memory subsystem
// per-port reference models, hit latency, eviction, cross-port and random traffic
`timescale 1ns/10ps
`default_nettype none
`include "mem_system_settings.svh"

module tb_mem_system;

   // per-request wait limit in cycles
   localparam int          REQ_LIMIT      = 200;
   // about 300 requests at up to 20 cycles each, plus margin
   localparam int          TIMEOUT_CYCLES = 20000;
   localparam int unsigned SEED           = 32'h47d1_6a1e;
   localparam int          RANDOM_OPS     = 125;

   logic clk;
   logic rst;

   // cpu side of both ports
   logic [`MS_ADDR_W-1:0] addr     [`MS_PORTS];
   logic [`MS_DATA_W-1:0] data_in  [`MS_PORTS];
   logic [`MS_PORTS-1:0]  rd;
   logic [`MS_PORTS-1:0]  wr;
   logic [`MS_DATA_W-1:0] data_out [`MS_PORTS];
   logic [`MS_PORTS-1:0]  done;
   logic [`MS_PORTS-1:0]  stall;
   logic [`MS_PORTS-1:0]  cache_hit;
   logic [`MS_PORTS-1:0]  err;

   // reference data per port, unwritten words read as zero
   bit [`MS_DATA_W-1:0] model0 [bit [`MS_ADDR_W-1:0]];
   bit [`MS_DATA_W-1:0] model1 [bit [`MS_ADDR_W-1:0]];

   int cycles = 0;
   int errors = 0;
   int checks = 0;
   int tests  = 0;
   int failed = 0;

   tb_clock u_clock (
      .clk (clk),
      .rst (rst)
   );

   mem_system UUT (
      .clk       (clk),
      .rst       (rst),
      .addr      (addr),
      .data_in   (data_in),
      .rd        (rd),
      .wr        (wr),
      .data_out  (data_out),
      .done      (done),
      .stall     (stall),
      .cache_hit (cache_hit),
      .err       (err)
   );

   // run limit
   always @(posedge clk) begin
      cycles <= cycles + 1;
      if (cycles >= TIMEOUT_CYCLES) begin
         $display("timeout: run did not finish within %0d cycles", TIMEOUT_CYCLES);
         $display("=== FAIL ===");
         $finish;
      end
   end

   function automatic logic [15:0] model_read(input int p, input logic [15:0] a);
      if (p == 0) begin
         return model0.exists(a) ? model0[a] : 16'h0;
      end
      return model1.exists(a) ? model1[a] : 16'h0;
   endfunction

   task automatic model_write(input int p, input logic [15:0] a, input logic [15:0] d);
      if (p == 0) begin
         model0[a] = d;
      end else begin
         model1[a] = d;
      end
   endtask

   task automatic expect_eq(input string name, input logic [15:0] exp, input logic [15:0] act);
      checks++;
      assert (act === exp) else begin
         $display("Fail %s: expected %h, actual %h", name, exp, act);
         errors++;
      end
   endtask

   // drive on the rising edge, sample at the falling edge until done
   // lat counts falling edges after the drive, a hit gives 2
   task automatic cpu_request(input string name, input int p, input bit r, input bit w,
                              input logic [15:0] a, input logic [15:0] d,
                              output logic [15:0] q, output logic hit, output logic e,
                              output int lat);
      lat = 0;
      @(posedge clk);
      rd[p]      <= r;
      wr[p]      <= w;
      addr[p]    <= a;
      data_in[p] <= d;
      @(negedge clk);
      while (!done[p] && lat < REQ_LIMIT) begin
         // accepted from the second falling edge on
         if (lat > 0) begin
            expect_eq({name, " stall busy"}, 16'h1, 16'(stall[p]));
         end
         lat++;
         @(negedge clk);
      end
      checks++;
      assert (done[p]) else begin
         $display("%s: port %0d gave no Done within %0d cycles for addr %h",
                  name, p, REQ_LIMIT, a);
         errors++;
      end
      expect_eq({name, " stall at done"}, 16'h0, 16'(stall[p]));
      q   = data_out[p];
      hit = cache_hit[p];
      e   = err[p];
      // drop the request once done was seen
      @(posedge clk);
      rd[p] <= 1'b0;
      wr[p] <= 1'b0;
   endtask

   task automatic write_word(input string name, input int p, input logic [15:0] a,
                             input logic [15:0] d);
      logic [15:0] q;
      logic        hit;
      logic        e;
      int          lat;
      cpu_request(name, p, 1'b0, 1'b1, a, d, q, hit, e, lat);
      model_write(p, a, d);
      expect_eq({name, " err"}, 16'h0, 16'(e));
   endtask

   // owner picks the model that holds the word, exp_hit below 0 skips the hit check
   task automatic read_expect(input string name, input int p, input logic [15:0] a,
                              input int owner, input int exp_hit);
      logic [15:0] q;
      logic        hit;
      logic        e;
      int          lat;
      cpu_request(name, p, 1'b1, 1'b0, a, 16'h0, q, hit, e, lat);
      expect_eq({name, " data"}, model_read(owner, a), q);
      expect_eq({name, " err"}, 16'h0, 16'(e));
      if (exp_hit >= 0) begin
         expect_eq({name, " hit"}, 16'(exp_hit), 16'(hit));
      end
   endtask

   task automatic report_test(input string name, input int errors_before);
      tests++;
      if (errors == errors_before) begin
         $display("test %s ok", name);
      end else begin
         failed++;
         $display("test %s failed, %0d errors", name, errors - errors_before);
      end
   endtask

   task automatic reset_and_hit_latency();
      logic [15:0] q;
      logic        hit;
      logic        e;
      int          lat;
      int          e0;
      e0 = errors;
      expect_eq("reset_hit reset done", 16'h0, 16'(done));
      expect_eq("reset_hit reset stall", 16'h0, 16'(stall));
      expect_eq("reset_hit reset cache_hit", 16'h0, 16'(cache_hit));
      expect_eq("reset_hit reset err", 16'h0, 16'(err));
      expect_eq("reset_hit reset data_out0", 16'h0, data_out[0]);
      expect_eq("reset_hit reset data_out1", 16'h0, data_out[1]);
      write_word("reset_hit write", 0, 16'h0010, 16'h1234);
      cpu_request("reset_hit read", 0, 1'b1, 1'b0, 16'h0010, 16'h0, q, hit, e, lat);
      expect_eq("reset_hit latency", 16'd2, 16'(lat));
      expect_eq("reset_hit hit", 16'h1, 16'(hit));
      expect_eq("reset_hit data", model_read(0, 16'h0010), q);
      report_test("reset_hit", e0);
   endtask

   // A and B share index 0x21
   task automatic dirty_eviction();
      int e0;
      e0 = errors;
      write_word("dirty_evict write A", 0, 16'h0021, 16'hA5A5);
      write_word("dirty_evict write B", 0, 16'h0061, 16'h5A5A);
      read_expect("dirty_evict read A", 0, 16'h0021, 0, 0);
      read_expect("dirty_evict read B", 0, 16'h0061, 0, 0);
      read_expect("dirty_evict reread B", 0, 16'h0061, 0, 1);
      report_test("dirty_evict", e0);
   endtask

   // D pushes C out of port 0, port 1 finds C in memory
   task automatic cross_port_visibility();
      int e0;
      e0 = errors;
      write_word("cross_port write C", 0, 16'h0102, 16'hC0DE);
      write_word("cross_port write D", 0, 16'h0142, 16'hD00D);
      read_expect("cross_port port1 read C", 1, 16'h0102, 0, 0);
      report_test("cross_port", e0);
   endtask

   // port 0 misses with a dirty victim, port 1 with a clean line
   task automatic concurrent_misses();
      int e0;
      e0 = errors;
      fork
         read_expect("concurrent port0 read C", 0, 16'h0102, 0, 0);
         read_expect("concurrent port1 read A", 1, 16'h0021, 0, 0);
      join
      report_test("concurrent_miss", e0);
   endtask

   task automatic illegal_request();
      logic [15:0] q;
      logic        hit;
      logic        e;
      int          lat;
      int          e0;
      e0 = errors;
      cpu_request("illegal_req", 0, 1'b1, 1'b1, 16'h0203, 16'hBEEF, q, hit, e, lat);
      expect_eq("illegal_req err", 16'h1, 16'(e));
      // nothing may have been stored
      read_expect("illegal_req read back", 0, 16'h0203, 0, -1);
      report_test("illegal_req", e0);
   endtask

   // own half per port, 4 tags over 8 lines for hits and evictions
   task automatic random_port_ops(input int p, input int n);
      logic [15:0] a;
      logic [15:0] d;
      bit          is_wr;
      for (int i = 0; i < n; i++) begin
         is_wr = 1'($urandom_range(1, 0));
         a     = {1'(p), 7'h0, 2'($urandom_range(3, 0)), 3'h0, 3'($urandom_range(7, 0))};
         d     = 16'($urandom);
         if (is_wr) begin
            write_word($sformatf("random p%0d write %h", p, a), p, a, d);
         end else begin
            read_expect($sformatf("random p%0d read %h", p, a), p, a, p, -1);
         end
      end
   endtask

   task automatic random_traffic();
      int e0;
      e0 = errors;
      fork
         random_port_ops(0, RANDOM_OPS);
         random_port_ops(1, RANDOM_OPS);
      join
      report_test("random_traffic", e0);
   endtask

   initial begin
      void'($urandom(SEED));
      rd = '0;
      wr = '0;
      for (int p = 0; p < `MS_PORTS; p++) begin
         addr[p]    = '0;
         data_in[p] = '0;
      end
      @(negedge rst);
      @(negedge clk);
      reset_and_hit_latency();
      dirty_eviction();
      cross_port_visibility();
      concurrent_misses();
      illegal_request();
      random_traffic();
      $display("%0d tests, %0d failed, %0d checks, %0d errors", tests, failed, checks, errors);
      if (errors == 0) begin
         $display("=== PASS ===");
      end else begin
         $display("=== FAIL ===");
      end
      $finish;
   end

endmodule

`default_nettype wire

//--- tests/tb_clock.sv
// clock and reset source for the memory subsystem testbench
// 10 ns clock, reset held high for the first cycles
`timescale 1ns/10ps
`default_nettype none

module tb_clock #(
   parameter int RESET_CYCLES = 10
) (
   output logic clk,
   output logic rst
);

   // 10 ns period
   initial begin
      clk = 1'b0;
      forever #5 clk = ~clk;
   end

   // release on a rising edge
   initial begin
      rst = 1'b1;
      repeat (RESET_CYCLES) @(posedge clk);
      rst <= 1'b0;
   end

endmodule

`default_nettype wire

//--- src/mem_system.sv
// top level, one cache controller per port sharing the banked memory
// all cpu-side signals are indexed by port
`timescale 1ns/10ps
`default_nettype none
`include "mem_system_settings.svh"

module mem_system (
   input  logic                  clk,
   input  logic                  rst,
   input  logic [`MS_ADDR_W-1:0] addr      [`MS_PORTS],
   input  logic [`MS_DATA_W-1:0] data_in   [`MS_PORTS],
   input  logic [`MS_PORTS-1:0]  rd,
   input  logic [`MS_PORTS-1:0]  wr,
   output logic [`MS_DATA_W-1:0] data_out  [`MS_PORTS],
   output logic [`MS_PORTS-1:0]  done,
   output logic [`MS_PORTS-1:0]  stall,
   output logic [`MS_PORTS-1:0]  cache_hit,
   output logic [`MS_PORTS-1:0]  err
);

   // controller side of the arbiter
   mem_system_pkg::mem_req_t port_req [`MS_PORTS];
   mem_system_pkg::mem_rsp_t port_rsp [`MS_PORTS];

   // arbiter to memory
   mem_system_pkg::mem_req_t mem_req;
   mem_system_pkg::mem_rsp_t mem_rsp;

   for (genvar p = 0; p < `MS_PORTS; p++) begin : g_port
      cache_ctrl u_ctrl (
         .clk       (clk),
         .rst       (rst),
         .addr      (addr[p]),
         .data_in   (data_in[p]),
         .rd        (rd[p]),
         .wr        (wr[p]),
         .data_out  (data_out[p]),
         .done      (done[p]),
         .stall     (stall[p]),
         .cache_hit (cache_hit[p]),
         .err       (err[p]),
         .mem_req   (port_req[p]),
         .mem_rsp   (port_rsp[p])
      );
   end

   mem_arbiter u_arbiter (
      .clk      (clk),
      .rst      (rst),
      .port_req (port_req),
      .port_rsp (port_rsp),
      .mem_req  (mem_req),
      .mem_rsp  (mem_rsp)
   );

   banked_mem u_mem (
      .clk (clk),
      .rst (rst),
      .req (mem_req),
      .rsp (mem_rsp)
   );

endmodule

`default_nettype wire

//--- src/banked_mem.sv
// backing word memory in four banks with fixed access latency
// answers each request with a four-phase ack
`timescale 1ns/10ps
`default_nettype none
`include "mem_system_settings.svh"

module banked_mem (
   input  logic                     clk,
   input  logic                     rst,
   input  mem_system_pkg::mem_req_t req,
   output mem_system_pkg::mem_rsp_t rsp
);

   localparam int ROW_W = `MS_ADDR_W - 2;
   localparam int ROWS  = 1 << ROW_W;
   localparam int CNT_W = $clog2(`MS_MEM_LAT + 1);

   // bank picked by the low address bits
   logic [`MS_DATA_W-1:0] bank_mem [4][ROWS];

   logic [CNT_W-1:0]      cnt_q;
   logic                  ack_q;
   logic [`MS_DATA_W-1:0] rdata_q;
   logic [1:0]            bank_sel;
   logic [ROW_W-1:0]      row;
   logic                  fire;

   assign bank_sel = req.addr[1:0];
   assign row      = req.addr[`MS_ADDR_W-1:2];

   // access cycle, also the cycle ack rises
   assign fire = req.req && !ack_q && (cnt_q == CNT_W'(`MS_MEM_LAT));

   // block ram contents start cleared
   initial begin
      for (int b = 0; b < 4; b++) begin
         for (int r = 0; r < ROWS; r++) begin
            bank_mem[b][r] = '0;
         end
      end
   end

   always_ff @(posedge clk or posedge rst) begin
      if (rst) begin
         cnt_q <= '0;
         ack_q <= 1'b0;
      end else if (ack_q) begin
         // drop ack one cycle after req falls
         cnt_q <= '0;
         if (!req.req) begin
            ack_q <= 1'b0;
         end
      end else if (fire) begin
         ack_q <= 1'b1;
         cnt_q <= '0;
      end else if (req.req) begin
         cnt_q <= cnt_q + 1'b1;
      end else begin
         cnt_q <= '0;
      end
   end

   always_ff @(posedge clk) begin
      if (fire) begin
         if (req.op == mem_system_pkg::MEM_WR) begin
            bank_mem[bank_sel][row] <= req.wdata;
         end else begin
            rdata_q <= bank_mem[bank_sel][row];
         end
      end
   end

   // rdata stays put for the whole ack phase
   assign rsp.ack   = ack_q;
   assign rsp.rdata = rdata_q;

endmodule

`default_nettype wire

//--- src/mem_arbiter.sv
// round-robin arbiter between the cache ports and the banked memory
// a grant covers one whole four-phase transfer
`timescale 1ns/10ps
`default_nettype none
`include "mem_system_settings.svh"

module mem_arbiter (
   input  logic                     clk,
   input  logic                     rst,
   input  mem_system_pkg::mem_req_t port_req [`MS_PORTS],
   output mem_system_pkg::mem_rsp_t port_rsp [`MS_PORTS],
   output mem_system_pkg::mem_req_t mem_req,
   input  mem_system_pkg::mem_rsp_t mem_rsp
);

   localparam int PORT_W = (`MS_PORTS > 1) ? $clog2(`MS_PORTS) : 1;

   logic              busy_q;
   logic [PORT_W-1:0] owner_q;
   // highest-priority port for the next grant
   logic [PORT_W-1:0] prio_q;
   logic [PORT_W-1:0] pick;
   logic              pick_vld;
   logic              release_now;

   // scan from prio_q upward, nearest requester wins
   always_comb begin
      int unsigned idx;
      pick     = prio_q;
      pick_vld = 1'b0;
      for (int i = `MS_PORTS - 1; i >= 0; i--) begin
         idx = (int'(prio_q) + i) % `MS_PORTS;
         if (port_req[idx].req) begin
            pick     = PORT_W'(idx);
            pick_vld = 1'b1;
         end
      end
   end

   // transfer over once owner dropped req and memory dropped ack
   assign release_now = busy_q && !port_req[owner_q].req && !mem_rsp.ack;

   always_ff @(posedge clk or posedge rst) begin
      if (rst) begin
         busy_q  <= 1'b0;
         owner_q <= '0;
         prio_q  <= '0;
      end else if (!busy_q && pick_vld) begin
         busy_q  <= 1'b1;
         owner_q <= pick;
         prio_q  <= PORT_W'((int'(pick) + 1) % `MS_PORTS);
      end else if (release_now) begin
         busy_q <= 1'b0;
      end
   end

   assign mem_req = busy_q ? port_req[owner_q] : '0;

   // response to the owner only
   always_comb begin
      for (int i = 0; i < `MS_PORTS; i++) begin
         port_rsp[i] = (busy_q && owner_q == PORT_W'(i)) ? mem_rsp : '0;
      end
   end

endmodule

`default_nettype wire

//--- src/cache_ctrl.sv
// per-port cache controller, CPU request in, four-phase memory request out
// write-back and write-allocate, write misses fill the line without a fetch
`timescale 1ns/10ps
`default_nettype none
`include "mem_system_settings.svh"

module cache_ctrl (
   input  logic                     clk,
   input  logic                     rst,
   input  logic [`MS_ADDR_W-1:0]    addr,
   input  logic [`MS_DATA_W-1:0]    data_in,
   input  logic                     rd,
   input  logic                     wr,
   output logic [`MS_DATA_W-1:0]    data_out,
   output logic                     done,
   output logic                     stall,
   output logic                     cache_hit,
   output logic                     err,
   output mem_system_pkg::mem_req_t mem_req,
   input  mem_system_pkg::mem_rsp_t mem_rsp
);

   localparam int TAG_W = `MS_ADDR_W - `MS_INDEX_W;

   mem_system_pkg::ctrl_state_e state_q;
   mem_system_pkg::ctrl_state_e state_d;

   logic [`MS_INDEX_W-1:0] index;
   logic [TAG_W-1:0]       tag;
   logic [TAG_W-1:0]       victim_tag;
   logic                   line_hit;
   logic                   line_dirty;
   logic [`MS_DATA_W-1:0]  line_data;

   // cache write controls
   logic                   arr_wr;
   logic                   arr_dirty;
   logic [`MS_DATA_W-1:0]  arr_data;

   // next values of the registered cpu outputs
   logic                   done_d;
   logic                   hit_d;
   logic                   err_d;
   logic [`MS_DATA_W-1:0]  data_d;

   // word caught while the fetch ack is high
   logic [`MS_DATA_W-1:0]  fill_q;

   assign index = addr[`MS_INDEX_W-1:0];
   assign tag   = addr[`MS_ADDR_W-1:`MS_INDEX_W];

   cache_array u_array (
      .clk        (clk),
      .rst        (rst),
      .index      (index),
      .tag        (tag),
      .wr_en      (arr_wr),
      .wr_tag     (tag),
      .wr_data    (arr_data),
      .set_dirty  (arr_dirty),
      .hit        (line_hit),
      .dirty      (line_dirty),
      .victim_tag (victim_tag),
      .rd_data    (line_data)
   );

   // busy from accept until the cycle done goes high
   assign stall = (state_q != mem_system_pkg::IDLE);

   always_comb begin
      state_d   = state_q;
      done_d    = 1'b0;
      hit_d     = 1'b0;
      err_d     = 1'b0;
      data_d    = data_out;
      arr_wr    = 1'b0;
      arr_dirty = 1'b0;
      arr_data  = data_in;
      // idle bus unless a transfer state drives it
      mem_req       = '0;
      mem_req.op    = mem_system_pkg::MEM_RD;
      mem_req.addr  = addr;
      mem_req.wdata = line_data;

      case (state_q)
         mem_system_pkg::IDLE: begin
            // skip the done cycle, cpu still shows the old request then
            if ((rd || wr) && !done) begin
               state_d = mem_system_pkg::COMPARE;
            end
         end

         mem_system_pkg::COMPARE: begin
            if (rd && wr) begin
               // illegal, nothing stored
               done_d  = 1'b1;
               err_d   = 1'b1;
               state_d = mem_system_pkg::IDLE;
            end else if (line_hit) begin
               done_d  = 1'b1;
               hit_d   = 1'b1;
               state_d = mem_system_pkg::IDLE;
               if (wr) begin
                  arr_wr    = 1'b1;
                  arr_dirty = 1'b1;
                  data_d    = data_in;
               end else begin
                  data_d = line_data;
               end
            end else if (line_dirty) begin
               state_d = mem_system_pkg::WRITEBACK;
            end else if (wr) begin
               // clean write miss, allocate straight away
               arr_wr    = 1'b1;
               arr_dirty = 1'b1;
               data_d    = data_in;
               done_d    = 1'b1;
               state_d   = mem_system_pkg::IDLE;
            end else begin
               state_d = mem_system_pkg::FETCH;
            end
         end

         mem_system_pkg::WRITEBACK: begin
            // victim address rebuilt from its stored tag
            mem_req.req  = 1'b1;
            mem_req.op   = mem_system_pkg::MEM_WR;
            mem_req.addr = {victim_tag, index};
            if (mem_rsp.ack) begin
               state_d = mem_system_pkg::WB_RELEASE;
            end
         end

         mem_system_pkg::WB_RELEASE: begin
            if (!mem_rsp.ack) begin
               if (wr) begin
                  arr_wr    = 1'b1;
                  arr_dirty = 1'b1;
                  data_d    = data_in;
                  done_d    = 1'b1;
                  state_d   = mem_system_pkg::IDLE;
               end else begin
                  state_d = mem_system_pkg::FETCH;
               end
            end
         end

         mem_system_pkg::FETCH: begin
            mem_req.req = 1'b1;
            if (mem_rsp.ack) begin
               state_d = mem_system_pkg::FETCH_RELEASE;
            end
         end

         mem_system_pkg::FETCH_RELEASE: begin
            // fill clean once the responder has let go
            if (!mem_rsp.ack) begin
               arr_wr   = 1'b1;
               arr_data = fill_q;
               data_d   = fill_q;
               done_d   = 1'b1;
               state_d  = mem_system_pkg::IDLE;
            end
         end

         default: state_d = mem_system_pkg::IDLE;
      endcase
   end

   always_ff @(posedge clk) begin
      if (state_q == mem_system_pkg::FETCH && mem_rsp.ack) begin
         fill_q <= mem_rsp.rdata;
      end
   end

   always_ff @(posedge clk or posedge rst) begin
      if (rst) begin
         state_q   <= mem_system_pkg::IDLE;
         done      <= 1'b0;
         cache_hit <= 1'b0;
         err       <= 1'b0;
         data_out  <= '0;
      end else begin
         state_q   <= state_d;
         done      <= done_d;
         cache_hit <= hit_d;
         err       <= err_d;
         data_out  <= data_d;
      end
   end

endmodule

`default_nettype wire

//--- src/cache_array.sv
// storage for one direct-mapped cache with one word per line
// combinational lookup by index, single write port for CPU writes and fills
`timescale 1ns/10ps
`default_nettype none
`include "mem_system_settings.svh"

module cache_array (
   input  logic                                clk,
   input  logic                                rst,
   input  logic [`MS_INDEX_W-1:0]              index,
   input  logic [`MS_ADDR_W-`MS_INDEX_W-1:0]   tag,
   input  logic                                wr_en,
   input  logic [`MS_ADDR_W-`MS_INDEX_W-1:0]   wr_tag,
   input  logic [`MS_DATA_W-1:0]               wr_data,
   input  logic                                set_dirty,
   output logic                                hit,
   output logic                                dirty,
   output logic [`MS_ADDR_W-`MS_INDEX_W-1:0]   victim_tag,
   output logic [`MS_DATA_W-1:0]               rd_data
);

   localparam int TAG_W = `MS_ADDR_W - `MS_INDEX_W;
   localparam int LINES = 1 << `MS_INDEX_W;

   // line status bits
   logic [LINES-1:0] valid_q;
   logic [LINES-1:0] dirty_q;

   // tag and data arrays
   logic [TAG_W-1:0]      tag_mem  [LINES];
   logic [`MS_DATA_W-1:0] data_mem [LINES];

   // lookup, all from the current index
   assign victim_tag = tag_mem[index];
   assign rd_data    = data_mem[index];
   assign hit        = valid_q[index] && (tag_mem[index] == tag);
   // only a valid line can need a writeback
   assign dirty      = valid_q[index] && dirty_q[index];

   always_ff @(posedge clk or posedge rst) begin
      if (rst) begin
         valid_q <= '0;
         dirty_q <= '0;
      end else if (wr_en) begin
         valid_q[index] <= 1'b1;
         // cpu write marks dirty, fill from memory leaves it clean
         dirty_q[index] <= set_dirty;
      end
   end

   always_ff @(posedge clk) begin
      if (wr_en) begin
         tag_mem[index]  <= wr_tag;
         data_mem[index] <= wr_data;
      end
   end

endmodule

`default_nettype wire

//--- src/mem_system_pkg.sv
// shared types for the cache controllers, the arbiter and the banked memory
// referenced by scoped names from each module
`default_nettype none
`include "mem_system_settings.svh"

package mem_system_pkg;

   // per-port controller states
   typedef enum logic [2:0] {
      IDLE,
      COMPARE,
      WRITEBACK,
      WB_RELEASE,
      FETCH,
      FETCH_RELEASE
   } ctrl_state_e;

   // backing memory operations
   typedef enum logic {
      MEM_RD,
      MEM_WR
   } mem_op_e;

   // request side of the four-phase handshake
   typedef struct packed {
      logic                  req;
      mem_op_e               op;
      logic [`MS_ADDR_W-1:0] addr;
      logic [`MS_DATA_W-1:0] wdata;
   } mem_req_t;

   // response side, rdata only meaningful while ack is high
   typedef struct packed {
      logic                  ack;
      logic [`MS_DATA_W-1:0] rdata;
   } mem_rsp_t;

endpackage

`default_nettype wire

//--- src/mem_system_settings.svh
// width, latency and port-count constants for the two-port memory subsystem
// include in any file that sizes buses or arrays
`ifndef MEM_SYSTEM_SETTINGS_SVH
`define MEM_SYSTEM_SETTINGS_SVH

// word address and data widths
`define MS_ADDR_W 16
`define MS_DATA_W 16

// direct-mapped index, tag takes the upper address bits
`define MS_INDEX_W 6

// cycles from req seen to ack raised in the backing memory
`define MS_MEM_LAT 3

// cache ports sharing the backing memory
`define MS_PORTS 2

`endif
